// File: project.f
+incdir+verilog
verilog/core_types_pkg.sv
verilog/aq_pkg.sv
verilog/aq_input_stage.sv
verilog/acquire_queue.sv
verilog/aq_advertiser.sv
verilog/aq_top.sv
tb/aq_props.sv
tb/aq_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the acquire queue testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module aq_tb \
	-Mdir obj_dir -o aq_sim -f project.f || { echo "build failed"; exit 1; }

out=$(./obj_dir/aq_sim +verilator+error+limit+1000 2>&1)
echo "$out"

echo "$out" | grep -qF '*** PASSED ***' && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb/aq_props.sv
// acquire queue properties
// structural checks bound to the queue top level: idle state after reset,
// ready level against the outstanding count, head validity

`timescale 1ns/1ps
`default_nettype none

`include "aq_macros.svh"

module aq_props
	import core_types_pkg::*, aq_pkg::*;
(
	input logic                       CLK,
	input logic                       nRST,
	input logic                       enq_ready,
	input aq_advert_t                 advert,
	input aq_entry_t                  entries [`AQ_ENTRIES],
	input logic [`AQ_LOG_ENTRIES-1:0] head_ptr,

	// ops in flight by the testbench model count
	input logic [`AQ_LOG_ENTRIES:0]   outstanding
);

	int unsigned violations = 0;
	logic [3:0]  since_reset;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			since_reset <= '0;
		end else if (since_reset != 4'hf) begin
			since_reset <= since_reset + 4'd1;
		end
	end

	// --------------------------------------------------
	// reset and ready
	// --------------------------------------------------

	reset_idle: assert property (@(posedge CLK) disable iff (!nRST)
		since_reset < 4'd4 |-> enq_ready && advert == '0)
		else begin
			$error("queue not idle in the first cycles after reset");
			violations++;
		end

	// model count reaches the queue state two edges later
	ready_when_room: assert property (@(posedge CLK) disable iff (!nRST)
		$past(outstanding, 2) < `AQ_ENTRIES |-> enq_ready)
		else begin
			$error("enq_ready low while the queue has room");
			violations++;
		end

	busy_when_full: assert property (@(posedge CLK) disable iff (!nRST)
		$past(outstanding, 2) == `AQ_ENTRIES |-> !enq_ready)
		else begin
			$error("enq_ready high while the queue is full");
			violations++;
		end

	head_valid: assert property (@(posedge CLK) disable iff (!nRST)
		$past(outstanding, 2) != 0 |-> entries[head_ptr].valid)
		else begin
			$error("head entry invalid while ops are queued");
			violations++;
		end

endmodule

`default_nettype wire

// File: tb/aq_tb.sv
// acquire queue testbench
// reference queue model, directed and random request traffic, and
// comparison of the advertisement and dequeue index with the model

`timescale 1ns/1ps
`default_nettype none

`include "aq_macros.svh"

module aq_tb
	import core_types_pkg::*, aq_pkg::*;
();

	localparam int CYCLE_LIMIT = 2000;
	localparam int ENQ  = 0;
	localparam int UPD  = 1;
	localparam int DEQ  = 2;
	localparam int KILL = 3;

	// mem and io flags of the fill sequence
	localparam logic [1:0] FILL_FLAGS [4] = '{2'b01, 2'b10, 2'b11, 2'b01};

	logic       CLK;
	logic       nRST;
	aq_op_t     enq;
	aq_op_t     update;
	logic       deq_valid;
	rob_index_t rob_head_index;
	rob_kill_t  rob_kill;
	logic       enq_ready;
	rob_index_t deq_rob_index;
	aq_advert_t advert;

	// reference model and ROB window
	aq_entry_t                model_q [$];
	rob_index_t               rob_head;
	rob_index_t               rob_tail;
	logic [`AQ_LOG_ENTRIES:0] outstanding;

	integer seed;
	int     error_count = 0;
	int     check_count = 0;
	int     cycle_count = 0;

	aq_top DUT (.*);

	bind aq_top aq_props u_props (
		.CLK         (CLK),
		.nRST        (nRST),
		.enq_ready   (enq_ready),
		.advert      (advert),
		.entries     (entries),
		.head_ptr    (head_ptr),
		.outstanding (aq_tb.outstanding)
	);

	initial CLK = 1'b0;
	always #20 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// --------------------------------------------------
	// model and checks
	// --------------------------------------------------

	function automatic rob_index_t head_distance(rob_index_t idx);
		return idx - rob_head;
	endfunction

	// first queued op of each kind, oldest first
	function automatic aq_advert_t expected_advert();
		aq_advert_t a;
		a = '0;
		foreach (model_q[i]) begin
			if (model_q[i].mem_aq && !a.mem_active) begin
				a.mem_active       = 1'b1;
				a.mem_oldest_index = model_q[i].rob_index;
			end
			if (model_q[i].io_aq && !a.io_active) begin
				a.io_active       = 1'b1;
				a.io_oldest_index = model_q[i].rob_index;
			end
		end
		return a;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		assert (got == exp) else begin
			$display("[FAIL] %s got %0h expected %0h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_outputs();
		aq_advert_t exp;
		exp = expected_advert();
		check_value("advert.mem_active", advert.mem_active, exp.mem_active);
		check_value("advert.mem_oldest_index", advert.mem_oldest_index, exp.mem_oldest_index);
		check_value("advert.io_active", advert.io_active, exp.io_active);
		check_value("advert.io_oldest_index", advert.io_oldest_index, exp.io_oldest_index);
		check_value("enq_ready", enq_ready, model_q.size() < `AQ_ENTRIES);
		if (model_q.size() > 0) begin
			check_value("deq_rob_index", deq_rob_index, model_q[0].rob_index);
		end
	endtask

	// one request per cycle; kills with room carry an enqueue that must be dropped
	task automatic issue_request(input int kind, input logic mem, input logic io,
		input rob_index_t arg);
		aq_op_t    op;
		rob_kill_t kill;
		op.valid     = 1'b1;
		op.mem_aq    = mem;
		op.io_aq     = io;
		op.rob_index = (kind == UPD) ? arg : rob_tail;
		kill.valid   = 1'b1;
		kill.index   = arg;
		@(posedge CLK);
		enq            <= (kind == ENQ || (kind == KILL && model_q.size() < `AQ_ENTRIES)) ?
			op : aq_op_t'(0);
		update         <= (kind == UPD) ? op : aq_op_t'(0);
		deq_valid      <= (kind == DEQ);
		rob_kill       <= (kind == KILL) ? kill : rob_kill_t'(0);
		rob_head_index <= rob_head;
		case (kind)
			ENQ: begin
				if (model_q.size() == `AQ_ENTRIES) begin
					$display("stimulus error: enqueue issued while the queue is full");
					error_count++;
				end else begin
					model_q.push_back(aq_entry_t'(op));
					rob_tail = rob_tail + rob_index_t'(1 + $unsigned($random(seed)) % 3);
				end
			end
			UPD: begin
				foreach (model_q[i]) begin
					if (model_q[i].rob_index == arg) begin
						model_q[i].mem_aq = mem;
						model_q[i].io_aq  = io;
					end
				end
			end
			DEQ: begin
				if (model_q.size() > 0) begin
					rob_head = model_q[0].rob_index + rob_index_t'(1);
					void'(model_q.pop_front());
				end
			end
			default: begin
				for (int i = model_q.size() - 1; i >= 0; i--) begin
					if (head_distance(model_q[i].rob_index) > arg) begin
						model_q.delete(i);
					end
				end
				if (int'(arg) + 1 < int'(head_distance(rob_tail))) begin
					rob_tail = rob_head + arg + rob_index_t'(1);
				end
			end
		endcase
		// ROB fully retired once nothing is queued
		if (model_q.size() == 0) begin
			rob_head = rob_tail;
		end
		outstanding <= (`AQ_LOG_ENTRIES+1)'(model_q.size());
	endtask

	// idle long enough for input, queue and advert stages
	task automatic settle_and_check();
		@(posedge CLK);
		enq       <= '0;
		update    <= '0;
		deq_valid <= 1'b0;
		rob_kill  <= '0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		compare_outputs();
	endtask

	task automatic random_burst();
		int         count;
		int         kind;
		logic [1:0] flags;
		rob_index_t arg;
		count = 1 + $unsigned($random(seed)) % 3;
		for (int j = 0; j < count; j++) begin
			kind  = $unsigned($random(seed)) % 6;
			flags = 2'($random(seed));
			arg   = rob_tail;
			// enqueue weighted up, never on a full queue
			if (kind == ENQ || kind > KILL) begin
				kind = (model_q.size() < `AQ_ENTRIES) ? ENQ : DEQ;
			end
			if (kind == UPD && model_q.size() > 0) begin
				arg = model_q[$unsigned($random(seed)) % model_q.size()].rob_index;
			end
			if (kind == KILL) begin
				arg = rob_index_t'($unsigned($random(seed)) % (int'(head_distance(rob_tail)) + 1));
			end
			issue_request(kind, flags[1], flags[0], arg);
		end
		settle_and_check();
	endtask

	// --------------------------------------------------
	// sequence
	// --------------------------------------------------

	initial begin
		seed           = 16;
		nRST           = 1'b0;
		enq            = '0;
		update         = '0;
		deq_valid      = 1'b0;
		rob_head_index = '0;
		rob_kill       = '0;
		rob_head       = '0;
		rob_tail       = '0;
		outstanding    = '0;
		repeat (10) @(posedge CLK);
		nRST <= 1'b1;
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		compare_outputs();

		// fill to full, ready drops after the fourth
		for (int i = 0; i < `AQ_ENTRIES; i++) begin
			issue_request(ENQ, FILL_FLAGS[i][1], FILL_FLAGS[i][0], '0);
			settle_and_check();
		end

		// clear the two memory acquires oldest first
		issue_request(UPD, 1'b0, model_q[1].io_aq, model_q[1].rob_index);
		settle_and_check();
		issue_request(UPD, 1'b0, model_q[2].io_aq, model_q[2].rob_index);
		settle_and_check();

		// drain in order, last strobe hits an empty queue
		repeat (`AQ_ENTRIES + 1) begin
			issue_request(DEQ, 1'b0, 1'b0, '0);
			settle_and_check();
		end

		// refill, kill the two youngest, then reuse the freed slots
		for (int i = 0; i < `AQ_ENTRIES; i++) begin
			issue_request(ENQ, FILL_FLAGS[i][1], FILL_FLAGS[i][0], '0);
		end
		settle_and_check();
		issue_request(KILL, 1'b1, 1'b1, head_distance(model_q[1].rob_index));
		settle_and_check();
		repeat (2) begin
			issue_request(ENQ, 1'b1, 1'b0, '0);
			settle_and_check();
		end

		repeat (60) random_burst();

		$display("checks: %0d  value errors: %0d  assertion failures: %0d",
			check_count, error_count, DUT.u_props.violations);
		if (error_count == 0 && DUT.u_props.violations == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/acquire_queue.sv
// acquire queue storage
// circular buffer of acquire ops in program order; takes enqueues at the
// tail, updates flags by ROB index, pops at the head on dequeue and
// trims younger entries off the tail on a ROB kill

`timescale 1ns/1ps
`default_nettype none

`include "aq_macros.svh"

module acquire_queue
	import core_types_pkg::*, aq_pkg::*;
(
	input  logic                       CLK,
	input  logic                       nRST,

	// captured requests
	input  aq_op_t                     enq_q,
	input  aq_op_t                     update_q,
	input  logic                       deq_q,
	input  rob_index_t                 head_q,
	input  rob_kill_t                  kill_q,

	// to the core
	output logic                       enq_ready,
	output rob_index_t                 deq_rob_index,

	// to the advertiser
	output aq_entry_t                  entries [`AQ_ENTRIES],
	output logic [`AQ_LOG_ENTRIES-1:0] head_ptr
);

	// --------------------------------------------------
	// pointers
	// --------------------------------------------------

	logic [`AQ_LOG_ENTRIES-1:0] tail_ptr;
	logic                       head_wrap;
	logic                       tail_wrap;

	logic full;
	logic empty;

	// next state
	aq_entry_t                n_entries [`AQ_ENTRIES];
	logic [`AQ_LOG_ENTRIES:0] n_head;
	logic [`AQ_LOG_ENTRIES:0] n_tail;

	// kill scan
	logic [`AQ_LOG_ENTRIES:0]   occupancy;
	logic [`AQ_LOG_ENTRIES:0]   keep_count;
	logic [`AQ_LOG_ENTRIES-1:0] slot;
	rob_index_t                 kill_age;

	assign full  = (head_ptr == tail_ptr) && (head_wrap != tail_wrap);
	assign empty = (head_ptr == tail_ptr) && (head_wrap == tail_wrap);

	assign enq_ready     = !full;
	assign deq_rob_index = entries[head_ptr].rob_index;

	// --------------------------------------------------
	// next state: enqueue, update, dequeue, kill
	// --------------------------------------------------

	always_comb begin
		n_entries  = entries;
		n_head     = {head_wrap, head_ptr};
		n_tail     = {tail_wrap, tail_ptr};
		occupancy  = '0;
		keep_count = '0;
		slot       = '0;
		kill_age   = rob_rel_age(kill_q.index, head_q);

		// enqueue at tail, dropped under a kill
		if (enq_q.valid && !full && !kill_q.valid) begin
			n_entries[tail_ptr].valid     = 1'b1;
			n_entries[tail_ptr].mem_aq    = enq_q.mem_aq;
			n_entries[tail_ptr].io_aq     = enq_q.io_aq;
			n_entries[tail_ptr].rob_index = enq_q.rob_index;
			n_tail = n_tail + 1'b1;
		end

		// flag update on every matching entry
		if (update_q.valid) begin
			for (int i = 0; i < `AQ_ENTRIES; i++) begin
				if (n_entries[i].valid && n_entries[i].rob_index == update_q.rob_index) begin
					n_entries[i].mem_aq = update_q.mem_aq;
					n_entries[i].io_aq  = update_q.io_aq;
				end
			end
		end

		// pop head, ignored when empty
		if (deq_q && !empty) begin
			n_entries[head_ptr].valid = 1'b0;
			n_head = n_head + 1'b1;
		end

		// kill younger ops
		// entries are in program order so the killed ones form a suffix,
		// and the survivor count from the head gives the new tail
		if (kill_q.valid) begin
			occupancy = n_tail - n_head;
			for (int i = 0; i < `AQ_ENTRIES; i++) begin
				slot = n_head[`AQ_LOG_ENTRIES-1:0] + `AQ_LOG_ENTRIES'(i);
				if (i < int'(occupancy)) begin
					if (rob_rel_age(n_entries[slot].rob_index, head_q) > kill_age) begin
						n_entries[slot].valid = 1'b0;
					end else begin
						keep_count = keep_count + 1'b1;
					end
				end
			end
			n_tail = n_head + keep_count;
		end
	end

	// --------------------------------------------------
	// state registers
	// --------------------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < `AQ_ENTRIES; i++) begin
				entries[i] <= '0;
			end
			head_ptr  <= '0;
			head_wrap <= 1'b0;
			tail_ptr  <= '0;
			tail_wrap <= 1'b0;
		end else begin
			entries   <= n_entries;
			head_ptr  <= n_head[`AQ_LOG_ENTRIES-1:0];
			head_wrap <= n_head[`AQ_LOG_ENTRIES];
			tail_ptr  <= n_tail[`AQ_LOG_ENTRIES-1:0];
			tail_wrap <= n_tail[`AQ_LOG_ENTRIES];
		end
	end

endmodule

`default_nettype wire

// File: verilog/aq_advertiser.sv
// acquire advertisement stage
// walks the queue from its head to find the oldest pending memory and
// I/O acquire, then registers the result for the rest of the core

`timescale 1ns/1ps
`default_nettype none

`include "aq_macros.svh"

module aq_advertiser
	import core_types_pkg::*, aq_pkg::*;
(
	input  logic                       CLK,
	input  logic                       nRST,

	// queue state
	input  aq_entry_t                  entries [`AQ_ENTRIES],
	input  logic [`AQ_LOG_ENTRIES-1:0] head_ptr,

	// oldest acquire of each kind
	output aq_advert_t                 advert
);

	logic                       mem_found;
	rob_index_t                 mem_index;
	logic                       io_found;
	rob_index_t                 io_index;
	logic [`AQ_LOG_ENTRIES-1:0] slot;

	// --------------------------------------------------
	// oldest-first search
	// --------------------------------------------------

	always_comb begin
		mem_found = 1'b0;
		mem_index = '0;
		io_found  = 1'b0;
		io_index  = '0;
		slot      = '0;

		for (int i = 0; i < `AQ_ENTRIES; i++) begin
			slot = head_ptr + `AQ_LOG_ENTRIES'(i);

			// first memory acquire in queue order
			if (entries[slot].valid && entries[slot].mem_aq && !mem_found) begin
				mem_found = 1'b1;
				mem_index = entries[slot].rob_index;
			end

			// first I/O acquire in queue order
			if (entries[slot].valid && entries[slot].io_aq && !io_found) begin
				io_found = 1'b1;
				io_index = entries[slot].rob_index;
			end
		end
	end

	// --------------------------------------------------
	// output register
	// --------------------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			advert <= '0;
		end else begin
			advert.mem_active       <= mem_found;
			advert.mem_oldest_index <= mem_index;
			advert.io_active        <= io_found;
			advert.io_oldest_index  <= io_index;
		end
	end

endmodule

`default_nettype wire

// File: verilog/aq_input_stage.sv
// acquire queue input stage
// captures every request into registers and turns the head-relative
// kill bound into an absolute ROB index for the queue

`timescale 1ns/1ps
`default_nettype none

`include "aq_macros.svh"

module aq_input_stage
	import core_types_pkg::*, aq_pkg::*;
(
	input  logic       CLK,
	input  logic       nRST,

	// requests from the core
	input  aq_op_t     enq,
	input  aq_op_t     update,
	input  logic       deq_valid,
	input  rob_index_t rob_head_index,
	input  rob_kill_t  rob_kill,

	// captured requests
	output aq_op_t     enq_q,
	output aq_op_t     update_q,
	output logic       deq_q,
	output rob_index_t head_q,
	output rob_kill_t  kill_q
);

	// kill bound made absolute against the current head
	rob_index_t kill_abs_index;

	assign kill_abs_index = rob_abs_index(rob_kill.index, rob_head_index);

	// --------------------------------------------------
	// capture registers
	// --------------------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			enq_q        <= '0;
			update_q     <= '0;
			deq_q        <= 1'b0;
			head_q       <= '0;
			kill_q       <= '0;
		end else begin
			// op enqueue and update
			enq_q        <= enq;
			update_q     <= update;

			// dequeue strobe
			deq_q        <= deq_valid;

			// ROB state
			head_q       <= rob_head_index;
			kill_q.valid <= rob_kill.valid;
			kill_q.index <= kill_abs_index;
		end
	end

endmodule

`default_nettype wire

// File: verilog/aq_macros.svh
// acquire queue sizing
// ROB size and acquire queue depth, shared by the packages and all RTL
// stages of the store/AMO/fence acquire queue

`ifndef AQ_MACROS_SVH
`define AQ_MACROS_SVH

// --------------------------------------------------
// reorder buffer
// --------------------------------------------------

// number of ROB entries
`define AQ_ROB_ENTRIES 64
// ROB index width
`define AQ_LOG_ROB_ENTRIES 6

// --------------------------------------------------
// acquire queue
// --------------------------------------------------

// queue depth, power of two
`define AQ_ENTRIES 4
// queue pointer width
`define AQ_LOG_ENTRIES 2

`endif

// File: verilog/aq_pkg.sv
// acquire queue types
// request op, stored queue entry and the oldest-acquire advertisement
// passed between the three stages

`default_nettype none

`include "aq_macros.svh"

package aq_pkg;

	import core_types_pkg::*;

	// enqueue and update request
	typedef struct packed {
		logic       valid;
		logic       mem_aq;
		logic       io_aq;
		rob_index_t rob_index;
	} aq_op_t;

	// --------------------------------------------------
	// queue storage
	// --------------------------------------------------

	typedef struct packed {
		logic       valid;
		logic       mem_aq;
		logic       io_aq;
		rob_index_t rob_index;
	} aq_entry_t;

	// oldest pending acquire of each kind
	// index is zero whenever its active bit is low
	typedef struct packed {
		logic       mem_active;
		rob_index_t mem_oldest_index;
		logic       io_active;
		rob_index_t io_oldest_index;
	} aq_advert_t;

endpackage

`default_nettype wire

// File: verilog/aq_top.sv
// acquire queue top level
// input capture, queue storage and oldest-acquire advertisement,
// chained as three pipeline stages

`timescale 1ns/1ps
`default_nettype none

`include "aq_macros.svh"

module aq_top
	import core_types_pkg::*, aq_pkg::*;
(
	input  logic       CLK,
	input  logic       nRST,

	// requests
	input  aq_op_t     enq,
	input  aq_op_t     update,
	input  logic       deq_valid,
	input  rob_index_t rob_head_index,
	input  rob_kill_t  rob_kill,

	// feedback and advertisement
	output logic       enq_ready,
	output rob_index_t deq_rob_index,
	output aq_advert_t advert
);

	// --------------------------------------------------
	// stage to stage
	// --------------------------------------------------

	aq_op_t                     enq_q;
	aq_op_t                     update_q;
	logic                       deq_q;
	rob_index_t                 head_q;
	rob_kill_t                  kill_q;

	aq_entry_t                  entries [`AQ_ENTRIES];
	logic [`AQ_LOG_ENTRIES-1:0] head_ptr;

	aq_input_stage u_input_stage (
		.CLK            (CLK),
		.nRST           (nRST),
		.enq            (enq),
		.update         (update),
		.deq_valid      (deq_valid),
		.rob_head_index (rob_head_index),
		.rob_kill       (rob_kill),
		.enq_q          (enq_q),
		.update_q       (update_q),
		.deq_q          (deq_q),
		.head_q         (head_q),
		.kill_q         (kill_q)
	);

	acquire_queue u_queue (
		.CLK           (CLK),
		.nRST          (nRST),
		.enq_q         (enq_q),
		.update_q      (update_q),
		.deq_q         (deq_q),
		.head_q        (head_q),
		.kill_q        (kill_q),
		.enq_ready     (enq_ready),
		.deq_rob_index (deq_rob_index),
		.entries       (entries),
		.head_ptr      (head_ptr)
	);

	aq_advertiser u_advertiser (
		.CLK      (CLK),
		.nRST     (nRST),
		.entries  (entries),
		.head_ptr (head_ptr),
		.advert   (advert)
	);

endmodule

`default_nettype wire

// File: verilog/core_types_pkg.sv
// core types
// ROB index and kill information shared across the core, plus the
// index arithmetic used to move between relative and absolute ages

`default_nettype none

`include "aq_macros.svh"

package core_types_pkg;

	// index into the ROB
	typedef logic [`AQ_LOG_ROB_ENTRIES-1:0] rob_index_t;

	// kill younger than index
	typedef struct packed {
		logic       valid;
		rob_index_t index;
	} rob_kill_t;

	// age of an absolute index relative to the ROB head
	function automatic rob_index_t rob_rel_age(rob_index_t idx, rob_index_t head);
		return rob_index_t'((int'(idx) - int'(head) + `AQ_ROB_ENTRIES) % `AQ_ROB_ENTRIES);
	endfunction

	// absolute index from a head-relative one
	function automatic rob_index_t rob_abs_index(rob_index_t rel, rob_index_t head);
		return rob_index_t'((int'(rel) + int'(head)) % `AQ_ROB_ENTRIES);
	endfunction

endpackage

`default_nettype wire
